// File: filelist.f
logic/csr_bus_pkg.sv
logic/csr_map_pkg.sv
logic/csr_retime.sv
logic/csr_demux.sv
logic/scratch_regs.sv
logic/counter_regs.sv
logic/counter_core.sv
logic/csr_subsystem.sv
testbench/csr_subsystem_tb.sv

// File: Makefile
TOP := csr_subsystem_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: testbench/csr_subsystem_tb.sv
// Testbench for the CSR subsystem
//   bus read and write tasks that measure response latency
//   compare tasks for data, response flags, latency and signal levels
//   directed tests for scratch words, lock word, decode errors and the counter
`timescale 1ns/10ps

module csr_subsystem_tb;
  import csr_bus_pkg::*;
  import csr_map_pkg::*;

  // The tests take a few hundred cycles
  localparam int    MAX_CYCLES      = 2000;
  localparam int    SCRATCH_LATENCY = 1;
  localparam int    COUNTER_LATENCY = 3;
  localparam int    DECERR_LATENCY  = 1;
  localparam strb_t FULL_STRB       = 4'hF;
  localparam data_t EN_WORD         = data_t'(1) << CTRL_EN_BIT;
  localparam data_t CLR_WORD        = data_t'(1) << CTRL_CLR_BIT;
  localparam data_t MATCH_WORD      = data_t'(1) << STATUS_MATCH_BIT;

  logic  clk;
  logic  rst_n;
  logic  req_valid;
  logic  req_write;
  addr_t req_addr;
  data_t req_wdata;
  strb_t req_wstrb;
  logic  req_privileged;
  logic  resp_valid;
  data_t resp_rdata;
  logic  resp_decerr;
  logic  resp_slverr;
  logic  count_event;
  logic  counter_irq;

  // Response captured by the last bus access
  data_t last_rdata;
  logic  last_decerr;
  logic  last_slverr;
  int    last_latency;

  data_t  scratch_model [NUM_REGS];
  integer seed;
  int     cycles;
  int     data_errors    = 0;
  int     flag_errors    = 0;
  int     latency_errors = 0;
  int     level_errors   = 0;

  csr_subsystem i_csr_subsystem (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_write     (req_write),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .req_wstrb     (req_wstrb),
    .req_privileged(req_privileged),
    .resp_valid    (resp_valid),
    .resp_rdata    (resp_rdata),
    .resp_decerr   (resp_decerr),
    .resp_slverr   (resp_slverr),
    .count_event   (count_event),
    .counter_irq   (counter_irq)
  );

  // 100 ns clock period
  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic addr_t word_addr(input addr_t base, input logic [IDX_W-1:0] idx);
    return base + addr_t'({idx, {IDX_LSB{1'b0}}});
  endfunction

  function automatic data_t apply_strobes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
    data_t result;
    result = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  // One request strobe, then wait for the response sampled mid-cycle
  task automatic bus_access(input logic write, input addr_t addr, input data_t wdata,
                            input strb_t strb, input logic priv);
    @(posedge clk);
    #1;
    req_valid      = 1'b1;
    req_write      = write;
    req_addr       = addr;
    req_wdata      = wdata;
    req_wstrb      = strb;
    req_privileged = priv;
    @(posedge clk);
    #1;
    req_valid    = 1'b0;
    last_latency = 1;
    @(negedge clk);
    while (!resp_valid) begin
      @(negedge clk);
      last_latency++;
    end
    last_rdata  = resp_rdata;
    last_decerr = resp_decerr;
    last_slverr = resp_slverr;
  endtask

  task automatic bus_write(input addr_t addr, input data_t wdata, input strb_t strb,
                           input logic priv);
    bus_access(1'b1, addr, wdata, strb, priv);
  endtask

  task automatic bus_read(input addr_t addr, input logic priv);
    bus_access(1'b0, addr, '0, '0, priv);
  endtask

  task automatic pulse_events(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
      count_event = 1'b1;
      @(posedge clk);
      #1;
      count_event = 1'b0;
    end
  endtask

  task automatic check_data(input string what, input data_t got, input data_t expected);
    if (got !== expected) begin
      data_errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic check_flags(input string what, input logic exp_decerr, input logic exp_slverr);
    if (last_decerr !== exp_decerr || last_slverr !== exp_slverr) begin
      flag_errors++;
      $display("mismatch at %0t: %s decerr %b slverr %b, expected decerr %b slverr %b",
               $time, what, last_decerr, last_slverr, exp_decerr, exp_slverr);
    end
  endtask

  task automatic check_latency(input string what, input int expected);
    if (last_latency != expected) begin
      latency_errors++;
      $display("mismatch at %0t: %s answered after %0d cycles, expected %0d",
               $time, what, last_latency, expected);
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic expected);
    if (got !== expected) begin
      level_errors++;
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, expected);
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_level("resp_valid after reset", resp_valid, 1'b0);
    check_level("counter_irq after reset", counter_irq, 1'b0);
    bus_read(word_addr(COUNTER_BASE, COUNT_IDX), 1'b0);
    check_flags("count read after reset", 1'b0, 1'b0);
    check_data("count after reset", last_rdata, '0);
  endtask

  task automatic test_scratch_readback();
    strb_t part_strb [3];
    data_t wdata;
    addr_t addr;
    part_strb[0] = 4'b0101;
    part_strb[1] = 4'b1010;
    part_strb[2] = 4'b0110;
    for (int w = 0; w < 3; w++) begin
      addr  = word_addr(SCRATCH_BASE, w[IDX_W-1:0]);
      wdata = $random(seed);
      bus_write(addr, wdata, FULL_STRB, 1'b0);
      check_flags($sformatf("scratch %0d full write", w), 1'b0, 1'b0);
      scratch_model[w] = apply_strobes(scratch_model[w], wdata, FULL_STRB);
      bus_read(addr, 1'b0);
      check_data($sformatf("scratch %0d after full write", w), last_rdata, scratch_model[w]);
    end
    // Partial strobes keep the other bytes
    for (int w = 0; w < 3; w++) begin
      addr  = word_addr(SCRATCH_BASE, w[IDX_W-1:0]);
      wdata = $random(seed);
      bus_write(addr, wdata, part_strb[w], 1'b0);
      scratch_model[w] = apply_strobes(scratch_model[w], wdata, part_strb[w]);
      bus_read(addr, 1'b0);
      check_data($sformatf("scratch %0d after partial write", w), last_rdata,
                 scratch_model[w]);
    end
  endtask

  task automatic test_lock();
    addr_t lock_addr;
    data_t wdata;
    lock_addr = word_addr(SCRATCH_BASE, LOCK_IDX);
    wdata     = $random(seed);
    bus_write(lock_addr, wdata, FULL_STRB, 1'b1);
    check_flags("privileged lock write", 1'b0, 1'b0);
    scratch_model[LOCK_IDX] = apply_strobes(scratch_model[LOCK_IDX], wdata, FULL_STRB);
    bus_read(lock_addr, 1'b0);
    check_data("lock after privileged write", last_rdata, scratch_model[LOCK_IDX]);
    wdata = $random(seed);
    bus_write(lock_addr, wdata, FULL_STRB, 1'b0);
    check_flags("unprivileged lock write", 1'b0, 1'b1);
    bus_read(lock_addr, 1'b0);
    check_data("lock after unprivileged write", last_rdata, scratch_model[LOCK_IDX]);
  endtask

  task automatic test_decode_error();
    addr_t bad_addr [2];
    bad_addr[0] = 8'h10;
    bad_addr[1] = 8'h40;
    for (int i = 0; i < 2; i++) begin
      bus_read(bad_addr[i], 1'b0);
      check_flags($sformatf("read of %h", bad_addr[i]), 1'b1, 1'b0);
      check_data($sformatf("read of %h", bad_addr[i]), last_rdata, '0);
      check_latency($sformatf("read of %h", bad_addr[i]), DECERR_LATENCY);
      bus_write(bad_addr[i], $random(seed), FULL_STRB, 1'b1);
      check_flags($sformatf("write of %h", bad_addr[i]), 1'b1, 1'b0);
      check_data($sformatf("write of %h", bad_addr[i]), last_rdata, '0);
      check_latency($sformatf("write of %h", bad_addr[i]), DECERR_LATENCY);
    end
    bus_read(word_addr(SCRATCH_BASE, 2'd0), 1'b0);
    check_latency("scratch read", SCRATCH_LATENCY);
    bus_read(word_addr(COUNTER_BASE, COMPARE_IDX), 1'b0);
    check_latency("counter read", COUNTER_LATENCY);
  endtask

  task automatic test_counter();
    bus_write(word_addr(COUNTER_BASE, CTRL_IDX), EN_WORD, FULL_STRB, 1'b0);
    check_flags("ctrl enable write", 1'b0, 1'b0);
    check_latency("ctrl enable write", COUNTER_LATENCY);
    pulse_events(7);
    bus_read(word_addr(COUNTER_BASE, COUNT_IDX), 1'b0);
    check_data("count after 7 events", last_rdata, 32'd7);
    bus_write(word_addr(COUNTER_BASE, CTRL_IDX), EN_WORD | CLR_WORD, FULL_STRB, 1'b0);
    bus_read(word_addr(COUNTER_BASE, COUNT_IDX), 1'b0);
    check_data("count after clear", last_rdata, '0);
    // Clear bit reads back as zero
    bus_read(word_addr(COUNTER_BASE, CTRL_IDX), 1'b0);
    check_data("ctrl after clear", last_rdata, EN_WORD);
    bus_write(word_addr(COUNTER_BASE, COUNT_IDX), 32'h0000_0055, FULL_STRB, 1'b0);
    check_flags("count write", 1'b0, 1'b1);
    bus_read(word_addr(COUNTER_BASE, COUNT_IDX), 1'b0);
    check_data("count after count write", last_rdata, '0);
  endtask

  task automatic test_compare_irq();
    bus_write(word_addr(COUNTER_BASE, CTRL_IDX), CLR_WORD, FULL_STRB, 1'b0);
    bus_write(word_addr(COUNTER_BASE, COMPARE_IDX), 32'd5, FULL_STRB, 1'b0);
    bus_write(word_addr(COUNTER_BASE, STATUS_IDX), MATCH_WORD, FULL_STRB, 1'b0);
    @(negedge clk);
    check_level("counter_irq before events", counter_irq, 1'b0);
    bus_read(word_addr(COUNTER_BASE, STATUS_IDX), 1'b0);
    check_data("status before events", last_rdata, '0);
    bus_write(word_addr(COUNTER_BASE, CTRL_IDX), EN_WORD, FULL_STRB, 1'b0);
    pulse_events(5);
    // Match in the first cycle, interrupt in the next
    @(negedge clk);
    check_level("counter_irq in match cycle", counter_irq, 1'b0);
    @(negedge clk);
    check_level("counter_irq after match", counter_irq, 1'b1);
    bus_read(word_addr(COUNTER_BASE, STATUS_IDX), 1'b0);
    check_data("status after match", last_rdata, MATCH_WORD);
    bus_read(word_addr(COUNTER_BASE, COUNT_IDX), 1'b0);
    check_data("count at match", last_rdata, 32'd5);
    bus_write(word_addr(COUNTER_BASE, CTRL_IDX), '0, FULL_STRB, 1'b0);
    bus_write(word_addr(COUNTER_BASE, STATUS_IDX), MATCH_WORD, FULL_STRB, 1'b0);
    @(negedge clk);
    check_level("counter_irq after status clear", counter_irq, 1'b0);
    bus_read(word_addr(COUNTER_BASE, STATUS_IDX), 1'b0);
    check_data("status after clear", last_rdata, '0);
  endtask

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: tests did not finish within %0d clock cycles", MAX_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    seed           = 32'h2eb4_065e;
    rst_n          = 1'b0;
    req_valid      = 1'b0;
    req_write      = 1'b0;
    req_addr       = '0;
    req_wdata      = '0;
    req_wstrb      = '0;
    req_privileged = 1'b0;
    count_event    = 1'b0;
    for (int w = 0; w < NUM_REGS; w++) begin
      scratch_model[w] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset_state();
    test_scratch_readback();
    test_lock();
    test_decode_error();
    test_counter();
    test_compare_irq();

    @(posedge clk);
    $display("errors: data %0d, flags %0d, latency %0d, level %0d",
             data_errors, flag_errors, latency_errors, level_errors);
    if (data_errors + flag_errors + latency_errors + level_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: logic/csr_subsystem.sv
// CSR subsystem top level
//   address demux with per-target retiming
//   scratch register block on lane 0
//   counter register block and counter core on lane 1
`timescale 1ns/10ps

module csr_subsystem #(
  parameter int SCRATCH_STAGES = 0,
  parameter int COUNTER_STAGES = 1
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid,
  input  logic               req_write,
  input  csr_bus_pkg::addr_t req_addr,
  input  csr_bus_pkg::data_t req_wdata,
  input  csr_bus_pkg::strb_t req_wstrb,
  input  logic               req_privileged,
  output logic               resp_valid,
  output csr_bus_pkg::data_t resp_rdata,
  output logic               resp_decerr,
  output logic               resp_slverr,
  input  logic               count_event,
  output logic               counter_irq
);
  import csr_bus_pkg::*;
  import csr_map_pkg::*;

  logic [NUM_TARGETS-1:0]  tgt_req_valid;
  logic [NUM_TARGETS-1:0]  tgt_req_write;
  addr_t [NUM_TARGETS-1:0] tgt_req_addr;
  data_t [NUM_TARGETS-1:0] tgt_req_wdata;
  strb_t [NUM_TARGETS-1:0] tgt_req_wstrb;
  logic [NUM_TARGETS-1:0]  tgt_req_privileged;
  logic [NUM_TARGETS-1:0]  tgt_resp_valid;
  data_t [NUM_TARGETS-1:0] tgt_resp_rdata;
  logic [NUM_TARGETS-1:0]  tgt_resp_slverr;

  logic  counter_en;
  logic  counter_clr;
  logic  match;
  data_t compare;
  data_t count;

  csr_demux #(
    .SCRATCH_STAGES(SCRATCH_STAGES),
    .COUNTER_STAGES(COUNTER_STAGES)
  ) i_csr_demux (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_valid         (req_valid),
    .req_write         (req_write),
    .req_addr          (req_addr),
    .req_wdata         (req_wdata),
    .req_wstrb         (req_wstrb),
    .req_privileged    (req_privileged),
    .resp_valid        (resp_valid),
    .resp_rdata        (resp_rdata),
    .resp_decerr       (resp_decerr),
    .resp_slverr       (resp_slverr),
    .tgt_req_valid     (tgt_req_valid),
    .tgt_req_write     (tgt_req_write),
    .tgt_req_addr      (tgt_req_addr),
    .tgt_req_wdata     (tgt_req_wdata),
    .tgt_req_wstrb     (tgt_req_wstrb),
    .tgt_req_privileged(tgt_req_privileged),
    .tgt_resp_valid    (tgt_resp_valid),
    .tgt_resp_rdata    (tgt_resp_rdata),
    .tgt_resp_slverr   (tgt_resp_slverr)
  );

  scratch_regs i_scratch_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (tgt_req_valid[SCRATCH_LANE]),
    .req_write     (tgt_req_write[SCRATCH_LANE]),
    .req_addr      (tgt_req_addr[SCRATCH_LANE]),
    .req_wdata     (tgt_req_wdata[SCRATCH_LANE]),
    .req_wstrb     (tgt_req_wstrb[SCRATCH_LANE]),
    .req_privileged(tgt_req_privileged[SCRATCH_LANE]),
    .resp_valid    (tgt_resp_valid[SCRATCH_LANE]),
    .resp_rdata    (tgt_resp_rdata[SCRATCH_LANE]),
    .resp_slverr   (tgt_resp_slverr[SCRATCH_LANE])
  );

  // The counter block ignores the privileged attribute
  counter_regs i_counter_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (tgt_req_valid[COUNTER_LANE]),
    .req_write  (tgt_req_write[COUNTER_LANE]),
    .req_addr   (tgt_req_addr[COUNTER_LANE]),
    .req_wdata  (tgt_req_wdata[COUNTER_LANE]),
    .req_wstrb  (tgt_req_wstrb[COUNTER_LANE]),
    .resp_valid (tgt_resp_valid[COUNTER_LANE]),
    .resp_rdata (tgt_resp_rdata[COUNTER_LANE]),
    .resp_slverr(tgt_resp_slverr[COUNTER_LANE]),
    .count      (count),
    .match      (match),
    .counter_en (counter_en),
    .counter_clr(counter_clr),
    .counter_irq(counter_irq),
    .compare    (compare)
  );

  counter_core i_counter_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .count_event(count_event),
    .counter_en (counter_en),
    .counter_clr(counter_clr),
    .compare    (compare),
    .count      (count),
    .match      (match)
  );

endmodule

// File: logic/counter_core.sv
// Event counter core
//   clear has priority over counting
//   match is high while enabled and the count equals compare
`timescale 1ns/10ps

module counter_core (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               count_event,
  input  logic               counter_en,
  input  logic               counter_clr,
  input  csr_bus_pkg::data_t compare,
  output csr_bus_pkg::data_t count,
  output logic               match
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (counter_clr) begin
      count <= '0;
    end else if (counter_en && count_event) begin
      // wraps at the top of the range
      count <= count + 32'd1;
    end
  end

  assign match = counter_en && (count == compare);

endmodule

// File: logic/counter_regs.sv
// Event counter register block
//   CTRL with enable and self-clearing clear bit
//   COMPARE value, read-only COUNT
//   sticky STATUS match bit driving the interrupt
`timescale 1ns/10ps

module counter_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid,
  input  logic               req_write,
  input  csr_bus_pkg::addr_t req_addr,
  input  csr_bus_pkg::data_t req_wdata,
  input  csr_bus_pkg::strb_t req_wstrb,
  output logic               resp_valid,
  output csr_bus_pkg::data_t resp_rdata,
  output logic               resp_slverr,
  input  csr_bus_pkg::data_t count,
  input  logic               match,
  output logic               counter_en,
  output logic               counter_clr,
  output logic               counter_irq,
  output csr_bus_pkg::data_t compare
);
  import csr_bus_pkg::*;
  import csr_map_pkg::*;

  logic [IDX_W-1:0] idx;
  logic             wr;
  logic             wr_byte0;
  logic             match_q;
  data_t            rd_word;

  assign idx = req_addr[IDX_LSB +: IDX_W];
  assign wr  = req_valid && req_write;
  // Control and status fields all sit in byte 0
  assign wr_byte0 = wr && req_wstrb[0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      counter_en  <= 1'b0;
      counter_clr <= 1'b0;
      compare     <= '0;
      match_q     <= 1'b0;
    end else begin
      counter_clr <= wr_byte0 && (idx == CTRL_IDX) && req_wdata[CTRL_CLR_BIT];
      if (wr_byte0 && (idx == CTRL_IDX)) begin
        counter_en <= req_wdata[CTRL_EN_BIT];
      end
      if (wr && (idx == COMPARE_IDX)) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (req_wstrb[b]) begin
            compare[8*b +: 8] <= req_wdata[8*b +: 8];
          end
        end
      end
      // A new match wins over a clear in the same cycle
      if (match) begin
        match_q <= 1'b1;
      end else if (wr_byte0 && (idx == STATUS_IDX) && req_wdata[STATUS_MATCH_BIT]) begin
        match_q <= 1'b0;
      end
    end
  end

  always_comb begin
    rd_word = NO_RDATA;
    case (idx)
      CTRL_IDX:    rd_word[CTRL_EN_BIT] = counter_en;
      COMPARE_IDX: rd_word = compare;
      COUNT_IDX:   rd_word = count;
      STATUS_IDX:  rd_word[STATUS_MATCH_BIT] = match_q;
      default:     rd_word = NO_RDATA;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid  <= 1'b0;
      resp_slverr <= 1'b0;
    end else begin
      resp_valid  <= req_valid;
      resp_slverr <= wr && (idx == COUNT_IDX);
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      resp_rdata <= req_write ? NO_RDATA : rd_word;
    end
  end

  assign counter_irq = match_q;

  // Single outstanding requests keep CTRL writes at least two cycles apart
  a_clr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    counter_clr |=> !counter_clr);

endmodule

// File: logic/scratch_regs.sv
// Scratch register block
//   four byte-strobed words, the last one a lock word
//   unprivileged writes to the lock word are refused with slverr
`timescale 1ns/10ps

module scratch_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid,
  input  logic               req_write,
  input  csr_bus_pkg::addr_t req_addr,
  input  csr_bus_pkg::data_t req_wdata,
  input  csr_bus_pkg::strb_t req_wstrb,
  input  logic               req_privileged,
  output logic               resp_valid,
  output csr_bus_pkg::data_t resp_rdata,
  output logic               resp_slverr
);
  import csr_bus_pkg::*;
  import csr_map_pkg::*;

  data_t            words [NUM_REGS];
  logic [IDX_W-1:0] idx;
  logic             lock_denied;

  assign idx         = req_addr[IDX_LSB +: IDX_W];
  assign lock_denied = req_write && (idx == LOCK_IDX) && !req_privileged;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int w = 0; w < NUM_REGS; w++) begin
        words[w] <= '0;
      end
    end else if (req_valid && req_write && !lock_denied) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (req_wstrb[b]) begin
          words[idx][8*b +: 8] <= req_wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid  <= 1'b0;
      resp_slverr <= 1'b0;
    end else begin
      resp_valid  <= req_valid;
      resp_slverr <= req_valid && lock_denied;
    end
  end

  // Read returns the word as it was before any write in the same cycle
  always_ff @(posedge clk) begin
    if (req_valid) begin
      resp_rdata <= req_write ? NO_RDATA : words[idx];
    end
  end

endmodule

// File: logic/csr_demux.sv
// Register bus demux
//   address decode against the map package ranges
//   per-target request and response retiming
//   decode-error response for unclaimed addresses
//   one-hot merge of the responses back upstream
`timescale 1ns/10ps

module csr_demux #(
  parameter int SCRATCH_STAGES = 0,
  parameter int COUNTER_STAGES = 1
) (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             req_valid,
  input  logic                                             req_write,
  input  csr_bus_pkg::addr_t                               req_addr,
  input  csr_bus_pkg::data_t                               req_wdata,
  input  csr_bus_pkg::strb_t                               req_wstrb,
  input  logic                                             req_privileged,
  output logic                                             resp_valid,
  output csr_bus_pkg::data_t                               resp_rdata,
  output logic                                             resp_decerr,
  output logic                                             resp_slverr,
  output logic [csr_bus_pkg::NUM_TARGETS-1:0]              tgt_req_valid,
  output logic [csr_bus_pkg::NUM_TARGETS-1:0]              tgt_req_write,
  output csr_bus_pkg::addr_t [csr_bus_pkg::NUM_TARGETS-1:0] tgt_req_addr,
  output csr_bus_pkg::data_t [csr_bus_pkg::NUM_TARGETS-1:0] tgt_req_wdata,
  output csr_bus_pkg::strb_t [csr_bus_pkg::NUM_TARGETS-1:0] tgt_req_wstrb,
  output logic [csr_bus_pkg::NUM_TARGETS-1:0]              tgt_req_privileged,
  input  logic [csr_bus_pkg::NUM_TARGETS-1:0]              tgt_resp_valid,
  input  csr_bus_pkg::data_t [csr_bus_pkg::NUM_TARGETS-1:0] tgt_resp_rdata,
  input  logic [csr_bus_pkg::NUM_TARGETS-1:0]              tgt_resp_slverr
);
  import csr_bus_pkg::*;
  import csr_map_pkg::*;

  logic [NUM_TARGETS-1:0]  sel;
  logic [NUM_TARGETS-1:0]  lane_resp_valid;
  data_t [NUM_TARGETS-1:0] lane_resp_rdata;
  logic [NUM_TARGETS-1:0]  lane_resp_slverr;
  logic                    decerr_valid;
  logic                    outstanding;

  // Range check on the offset from base, so a zero base needs no special case
  assign sel[SCRATCH_LANE] =
      addr_t'(req_addr - SCRATCH_BASE) <= addr_t'(SCRATCH_LIMIT - SCRATCH_BASE);
  assign sel[COUNTER_LANE] =
      addr_t'(req_addr - COUNTER_BASE) <= addr_t'(COUNTER_LIMIT - COUNTER_BASE);

  for (genvar i = 0; i < NUM_TARGETS; i++) begin : g_lane
    localparam int STAGES = (i == SCRATCH_LANE) ? SCRATCH_STAGES : COUNTER_STAGES;

    csr_retime #(
      .WIDTH (REQ_W),
      .STAGES(STAGES)
    ) i_req_retime (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (req_valid && sel[i]),
      .in_data  ({req_write, req_addr, req_wdata, req_wstrb, req_privileged}),
      .out_valid(tgt_req_valid[i]),
      .out_data ({tgt_req_write[i], tgt_req_addr[i], tgt_req_wdata[i],
                  tgt_req_wstrb[i], tgt_req_privileged[i]})
    );

    csr_retime #(
      .WIDTH (RESP_W),
      .STAGES(STAGES)
    ) i_resp_retime (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (tgt_resp_valid[i]),
      .in_data  ({tgt_resp_slverr[i], tgt_resp_rdata[i]}),
      .out_valid(lane_resp_valid[i]),
      .out_data ({lane_resp_slverr[i], lane_resp_rdata[i]})
    );
  end

  // Unclaimed requests are answered here one cycle later
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      decerr_valid <= 1'b0;
      outstanding  <= 1'b0;
    end else begin
      decerr_valid <= req_valid && !(|sel);
      if (req_valid) begin
        outstanding <= 1'b1;
      end else if (resp_valid) begin
        outstanding <= 1'b0;
      end
    end
  end

  // At most one source is valid, so OR of the masked lanes selects it
  always_comb begin
    resp_rdata  = NO_RDATA;
    resp_slverr = 1'b0;
    for (int i = 0; i < NUM_TARGETS; i++) begin
      if (lane_resp_valid[i]) begin
        resp_rdata  = resp_rdata | lane_resp_rdata[i];
        resp_slverr = resp_slverr | lane_resp_slverr[i];
      end
    end
  end

  assign resp_valid  = decerr_valid || (|lane_resp_valid);
  assign resp_decerr = decerr_valid;

  a_ranges_disjoint: assert property (@(posedge clk) disable iff (!rst_n)
    (SCRATCH_LIMIT < COUNTER_BASE) || (COUNTER_LIMIT < SCRATCH_BASE));

  a_one_resp_source: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({decerr_valid, lane_resp_valid}));

  a_single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid |-> (!outstanding || resp_valid));

endmodule

// File: logic/csr_retime.sv
// Valid-qualified delay line
//   STAGES of zero passes the inputs straight through
//   valid bits are reset, data words only load with their valid
`timescale 1ns/10ps

module csr_retime #(
  parameter int WIDTH  = 1,
  parameter int STAGES = 0
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  output logic [WIDTH-1:0] out_data
);

  if (STAGES == 0) begin : g_wire
    assign out_valid = in_valid;
    assign out_data  = in_data;
  end else begin : g_pipe
    logic [STAGES-1:0] valid_q;
    logic [WIDTH-1:0]  data_q [STAGES];

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_q <= '0;
      end else begin
        valid_q[0] <= in_valid;
        for (int s = 1; s < STAGES; s++) begin
          valid_q[s] <= valid_q[s-1];
        end
      end
    end

    // Each stage only captures when a valid word moves into it
    always_ff @(posedge clk) begin
      if (in_valid) begin
        data_q[0] <= in_data;
      end
      for (int s = 1; s < STAGES; s++) begin
        if (valid_q[s-1]) begin
          data_q[s] <= data_q[s-1];
        end
      end
    end

    assign out_valid = valid_q[STAGES-1];
    assign out_data  = data_q[STAGES-1];
  end

endmodule

// File: logic/csr_map_pkg.sv
// Register map of the CSR subsystem
//   target lane numbers and address ranges
//   word index position within a target
//   scratch and counter register offsets and field bits
package csr_map_pkg;

  // Demux lanes
  localparam int SCRATCH_LANE = 0;
  localparam int COUNTER_LANE = 1;

  // Inclusive byte ranges of the targets
  localparam csr_bus_pkg::addr_t SCRATCH_BASE  = 8'h00;
  localparam csr_bus_pkg::addr_t SCRATCH_LIMIT = 8'h0F;
  localparam csr_bus_pkg::addr_t COUNTER_BASE  = 8'h20;
  localparam csr_bus_pkg::addr_t COUNTER_LIMIT = 8'h2F;

  // Word index taken from address bits 3:2
  localparam int IDX_LSB  = 2;
  localparam int IDX_W    = 2;
  localparam int NUM_REGS = 2 ** IDX_W;

  // Scratch block
  localparam logic [IDX_W-1:0] LOCK_IDX = 2'd3;

  // Counter block
  localparam logic [IDX_W-1:0] CTRL_IDX    = 2'd0;
  localparam logic [IDX_W-1:0] COMPARE_IDX = 2'd1;
  localparam logic [IDX_W-1:0] COUNT_IDX   = 2'd2;
  localparam logic [IDX_W-1:0] STATUS_IDX  = 2'd3;

  localparam int CTRL_EN_BIT      = 0;
  localparam int CTRL_CLR_BIT     = 1;
  localparam int STATUS_MATCH_BIT = 0;

endpackage

// File: logic/csr_bus_pkg.sv
// Register bus definitions shared by the CSR subsystem
//   address, data and byte strobe types
//   number of downstream targets
//   packed widths used to retime request and response lanes
package csr_bus_pkg;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // Downstream register targets behind the demux
  localparam int NUM_TARGETS = 2;

  // Request lane is write, addr, wdata, wstrb and privileged
  localparam int REQ_W = 1 + ADDR_W + DATA_W + STRB_W + 1;
  // Response lane is slverr and rdata
  localparam int RESP_W = 1 + DATA_W;

  // Read data returned by writes and by error responses
  localparam data_t NO_RDATA = '0;

endpackage
